//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = lab_board_tb
FILELIST  = lab_board.f
SIM_ARGS  = +verilator+error+limit+100000
LOG       = sim.log
FAIL_MSG  = === FAIL ===
PASS_MSG  = === PASS ===

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- bench/lab_board_props.sv
`include "lab_consts.svh"

module lab_board_props (
    input logic                btn,
    input logic                rst_n,
    input logic [`SW_W-1:0]    sw,
    input logic [`LED_W-1:0]   ledr,
    input display_pkg::seg_t   seg0,
    input display_pkg::seg_t   seg1,
    input display_pkg::seg_t   seg2,
    input display_pkg::seg_t   seg3
);
    import lab_ops_pkg::*;
    import display_pkg::*;

    // lit segments per hex digit, bit 0 is a, bit 6 is g
    localparam logic [6:0] seg_lit [16] = '{
        7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
        7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71
    };

    int                fail_count = 0;
    int                since_rst = 0;
    logic              rst_seen = 1'b0;
    logic [`SW_W-1:0]  sw_d1;
    logic [`SW_W-1:0]  sw_d2;
    logic [`LED_W-1:0] exp_ledr;
    seg_t              exp_seg0;
    seg_t              exp_seg1;
    seg_t              exp_seg2;

    function automatic seg_t model_hex(input logic [3:0] nib);
        return {1'b1, ~seg_lit[nib]};
    endfunction

    function automatic logic [`DATA_W-1:0] model_shift(
        input logic [`DATA_W-1:0] d, input int n, input logic right, input logic arith);
        logic [`DATA_W-1:0] o;
        logic               fill;
        fill = right && arith && d[`DATA_W-1];
        for (int i = 0; i < `DATA_W; i++) begin
            if (!right)
                o[i] = (i >= n) ? d[i-n] : 1'b0;
            else
                o[i] = (i + n < `DATA_W) ? d[i+n] : fill;
        end
        return o;
    endfunction

    function automatic logic [`LED_W-1:0] model_ledr(input logic [`SW_W-1:0] s);
        int                 ua, ub, sa, sb;
        logic [`DATA_W-1:0] r;
        logic               ov;
        logic               cy;
        logic [`LED_W-1:0]  l;
        ua = int'(s[3:0]);
        ub = int'(s[7:4]);
        sa = int'($signed(s[3:0]));
        sb = int'($signed(s[7:4]));
        ov = 1'b0;
        cy = 1'b0;
        if (s[`SW_MODE_BIT]) begin
            r = model_shift(s[7:0], int'(s[10:8]), s[11], s[12]);
        end else begin
            case (alu_op_e'(s[10:8]))
                op_add: begin
                    r  = 8'((ua + ub) & 15);
                    cy = (ua + ub) > 15;
                    ov = (sa + sb) > 7 || (sa + sb) < -8;
                end
                op_sub: begin
                    r  = 8'((ua - ub) & 15);
                    // carry means no borrow
                    cy = ua >= ub;
                    ov = (sa - sb) > 7 || (sa - sb) < -8;
                end
                op_not:  r = 8'(~ua & 15);
                op_and:  r = 8'(ua & ub);
                op_or:   r = 8'(ua | ub);
                op_xor:  r = 8'(ua ^ ub);
                op_slt:  r = (sa < sb) ? 8'd1 : 8'd0;
                default: r = (ua == ub) ? 8'd1 : 8'd0;
            endcase
        end
        l = '0;
        l[7:0] = r;
        l[8] = (r == 8'd0);
        l[9] = ov;
        l[10] = cy;
        return l;
    endfunction

    // sw as it was two edges back, when the shown result was sampled
    always @(posedge btn) begin
        sw_d1 <= sw;
        sw_d2 <= sw_d1;
        if (!rst_n) begin
            rst_seen  <= 1'b1;
            since_rst <= 0;
        end else if (since_rst < 2) begin
            since_rst <= since_rst + 1;
        end
    end

    always_comb begin
        exp_ledr = model_ledr(sw_d2);
        exp_seg0 = model_hex(exp_ledr[3:0]);
        exp_seg1 = model_hex(exp_ledr[7:4]);
        // S reads as a 5 on the digit
        exp_seg2 = model_hex(sw_d2[`SW_MODE_BIT] ? 4'h5 : 4'ha);
    end

    reset_ledr: assert property (@(posedge btn) rst_seen && since_rst < 2 |-> ledr == '0)
        else begin
            fail_count++;
            $error("ERROR t=%0t ledr got %h exp %h", $time, $sampled(ledr), 16'h0);
        end

    reset_seg: assert property (@(posedge btn)
        rst_seen && since_rst == 0 |-> {seg3, seg2, seg1, seg0} == 32'hffffffff)
        else begin
            fail_count++;
            $error("ERROR t=%0t seg3..seg0 got %h exp %h", $time,
                   $sampled({seg3, seg2, seg1, seg0}), 32'hffffffff);
        end

    ledr_ok: assert property (@(posedge btn) since_rst >= 2 |-> ledr == exp_ledr)
        else begin
            fail_count++;
            $error("ERROR t=%0t ledr got %h exp %h", $time, $sampled(ledr), $sampled(exp_ledr));
        end

    hex_ok: assert property (@(posedge btn)
        since_rst >= 2 |-> {seg1, seg0} == {exp_seg1, exp_seg0})
        else begin
            fail_count++;
            $error("ERROR t=%0t seg1,seg0 got %h exp %h", $time,
                   $sampled({seg1, seg0}), $sampled({exp_seg1, exp_seg0}));
        end

    glyph_ok: assert property (@(posedge btn) since_rst >= 2 |-> seg2 == exp_seg2)
        else begin
            fail_count++;
            $error("ERROR t=%0t seg2 got %h exp %h", $time, $sampled(seg2), $sampled(exp_seg2));
        end

    blank_ok: assert property (@(posedge btn) since_rst >= 2 |-> seg3 == 8'hff)
        else begin
            fail_count++;
            $error("ERROR t=%0t seg3 got %h exp %h", $time, $sampled(seg3), 8'hff);
        end

endmodule

//--- bench/lab_board_tb.sv
`include "lab_consts.svh"

module lab_board_tb;
    import lab_ops_pkg::*;

    localparam int edge_limit = 40;
    localparam int rst_limit  = 100;

    // corner operand pairs, a against b
    localparam logic [3:0] a_vals [6] = '{4'd7, 4'd8, 4'd15, 4'd3, 4'd5, 4'd0};
    localparam logic [3:0] b_vals [6] = '{4'd1, 4'd1, 4'd1, 4'd12, 4'd5, 4'd0};

    logic              btn;
    logic              rst_n;
    logic [`SW_W-1:0]  sw;
    logic [`LED_W-1:0] ledr;
    display_pkg::seg_t seg0;
    display_pkg::seg_t seg1;
    display_pkg::seg_t seg2;
    display_pkg::seg_t seg3;
    int                edge_count = 0;
    time               last_edge_t = 0;
    int                timeouts = 0;
    int                fails;

    tb_clock_gen clk_gen (
        .btn   (btn),
        .rst_n (rst_n)
    );

    lab_board_top uut (
        .btn   (btn),
        .rst_n (rst_n),
        .sw    (sw),
        .ledr  (ledr),
        .seg0  (seg0),
        .seg1  (seg1),
        .seg2  (seg2),
        .seg3  (seg3)
    );

    bind lab_board_top lab_board_props u_props (
        .btn  (btn),
        .rst_n(rst_n),
        .sw   (sw),
        .ledr (ledr),
        .seg0 (seg0),
        .seg1 (seg1),
        .seg2 (seg2),
        .seg3 (seg3)
    );

    always @(posedge btn) begin
        edge_count++;
        last_edge_t = $time;
    end

    function automatic logic [`SW_W-1:0] alu_word(
        input logic [3:0] a, input logic [3:0] b, input alu_op_e op);
        return {5'b0, op, b, a};
    endfunction

    function automatic logic [`SW_W-1:0] shift_word(
        input logic [7:0] d, input logic [2:0] n, input logic right, input logic arith);
        return {1'b1, 2'b0, arith, right, n, d};
    endfunction

    task automatic wait_reset_release();
        int waited;
        waited = 0;
        while (!rst_n && waited < rst_limit) begin
            #1;
            waited++;
        end
        if (!rst_n) begin
            timeouts++;
            $display("timeout at %0t: reset was never released", $time);
        end
    endtask

    task automatic wait_edges(input int n);
        int target;
        int waited;
        target = edge_count + n;
        waited = 0;
        while (edge_count < target && waited < edge_limit) begin
            #1;
            waited++;
        end
        if (edge_count < target) begin
            timeouts++;
            $display("timeout at %0t: btn stopped toggling", $time);
        end else begin
            // settle one unit after the edge just seen
            #(last_edge_t + 1 - $time);
        end
    endtask

    task automatic drive_next(input logic [`SW_W-1:0] v);
        wait_edges(1);
        sw = v;
    endtask

    initial begin
        logic [`SW_W-1:0] w;
        sw = '0;
        void'($urandom(32'hcec0));
        wait_reset_release();

        for (int k = 0; k < 8; k++) begin
            for (int p = 0; p < 6; p++) begin
                drive_next(alu_word(a_vals[p], b_vals[p], alu_op_e'(3'(k))));
            end
        end

        // sll, srl, sra over every amount, negative and positive words
        for (int m = 0; m < 3; m++) begin
            for (int n = 0; n < 8; n++) begin
                drive_next(shift_word(8'hb5, 3'(n), m != 0, m == 2));
                drive_next(shift_word(8'h4c, 3'(n), m != 0, m == 2));
            end
        end

        // mode flips on every edge
        for (int i = 0; i < 32; i++) begin
            w = 16'($urandom);
            w[`SW_MODE_BIT] = i[0];
            drive_next(w);
        end

        for (int i = 0; i < 200; i++) begin
            drive_next(16'($urandom));
        end

        // let the last two samples reach the outputs
        wait_edges(3);

        fails = uut.u_props.fail_count;
        $display("failed checks: %0d, timeouts: %0d", fails, timeouts);
        if (fails == 0 && timeouts == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- bench/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int period     = 4,
    parameter int rst_cycles = 4
) (
    output logic btn,
    output logic rst_n
);

    initial begin
        btn = 1'b0;
        forever #(period / 2) btn = ~btn;
    end

    // released one unit after the last reset edge
    initial begin
        rst_n = 1'b0;
        #(period * rst_cycles - 1) rst_n = 1'b1;
    end

endmodule

//--- design/alu_unit.sv
`include "lab_consts.svh"

module alu_unit (
    input  logic                   btn,
    input  logic                   rst_n,
    input  logic [`OPERAND_W-1:0]  a,
    input  logic [`OPERAND_W-1:0]  b,
    input  lab_ops_pkg::alu_op_e   op,
    output logic [`OPERAND_W-1:0]  res,
    output logic                   zero,
    output logic                   ovfl,
    output logic                   carry
);
    import lab_ops_pkg::*;

    logic [`OPERAND_W-1:0] b_eff;
    logic [`OPERAND_W:0]   sum;
    logic [`OPERAND_W-1:0] res_next;
    logic                  ovfl_next;
    logic                  carry_next;

    // sub runs as a + ~b + 1
    always_comb begin
        b_eff = (op == op_sub) ? ~b : b;
        sum = {1'b0, a} + {1'b0, b_eff} + {{`OPERAND_W{1'b0}}, op == op_sub};
    end

    always_comb begin
        res_next   = '0;
        ovfl_next  = 1'b0;
        carry_next = 1'b0;
        case (op)
            op_add, op_sub: begin
                res_next   = sum[`OPERAND_W-1:0];
                carry_next = sum[`OPERAND_W];
                // same operand signs, result sign flipped
                ovfl_next  = (a[`OPERAND_W-1] == b_eff[`OPERAND_W-1]) &&
                             (sum[`OPERAND_W-1] != a[`OPERAND_W-1]);
            end
            op_not: res_next = ~a;
            op_and: res_next = a & b;
            op_or:  res_next = a | b;
            op_xor: res_next = a ^ b;
            op_slt: res_next = {{(`OPERAND_W-1){1'b0}}, $signed(a) < $signed(b)};
            op_eq:  res_next = {{(`OPERAND_W-1){1'b0}}, a == b};
            default: res_next = '0;
        endcase
    end

    always_ff @(posedge btn) begin
        if (!rst_n) begin
            res   <= '0;
            zero  <= 1'b0;
            ovfl  <= 1'b0;
            carry <= 1'b0;
        end else begin
            res   <= res_next;
            zero  <= (res_next == '0);
            ovfl  <= ovfl_next;
            carry <= carry_next;
        end
    end

endmodule

//--- design/barrel_shifter.sv
`include "lab_consts.svh"

module barrel_shifter (
    input  logic                 btn,
    input  logic                 rst_n,
    input  logic [`DATA_W-1:0]   din,
    input  logic [`SHAMT_W-1:0]  shamt,
    input  logic                 right,
    input  logic                 arith,
    output logic [`DATA_W-1:0]   res
);
    import lab_ops_pkg::*;

    shift_kind_e        kind;
    logic [`DATA_W-1:0] stage [0:`SHAMT_W];

    // one stage of the log shifter, sra keeps the sign bit
    function automatic logic [`DATA_W-1:0] shift_step(
        input logic [`DATA_W-1:0] v,
        input int unsigned        n,
        input shift_kind_e        k
    );
        case (k)
            shift_sll: shift_step = v << n;
            shift_srl: shift_step = v >> n;
            shift_sra: shift_step = $unsigned($signed(v) >>> n);
            default:   shift_step = v;
        endcase
    endfunction

    always_comb begin
        if (!right)
            kind = shift_sll;
        else if (arith)
            kind = shift_sra;
        else
            kind = shift_srl;
    end

    // stage i shifts by 2**i when shamt[i] is set
    always_comb begin
        stage[0] = din;
        for (int i = 0; i < `SHAMT_W; i++) begin
            stage[i+1] = shamt[i] ? shift_step(stage[i], 1 << i, kind) : stage[i];
        end
    end

    always_ff @(posedge btn) begin
        if (!rst_n)
            res <= '0;
        else
            res <= stage[`SHAMT_W];
    end

endmodule

//--- design/display_pkg.sv
`include "lab_consts.svh"

package display_pkg;

    // active low, bit 7 is the dot, bits 6:0 are g..a
    typedef logic [`SEG_W-1:0] seg_t;

    // mode glyphs for the third digit
    typedef enum logic [1:0] {
        glyph_a     = 2'd0,
        glyph_s     = 2'd1,
        glyph_blank = 2'd2
    } glyph_e;

endpackage

//--- design/lab_board_top.sv
`include "lab_consts.svh"

module lab_board_top (
    input  logic                btn,
    input  logic                rst_n,
    input  logic [`SW_W-1:0]    sw,
    output logic [`LED_W-1:0]   ledr,
    output display_pkg::seg_t   seg0,
    output display_pkg::seg_t   seg1,
    output display_pkg::seg_t   seg2,
    output display_pkg::seg_t   seg3
);
    import lab_ops_pkg::*;

    alu_op_e               alu_op;
    logic [`OPERAND_W-1:0] alu_res;
    logic                  alu_zero;
    logic                  alu_ovfl;
    logic                  alu_carry;
    logic [`DATA_W-1:0]    shift_res;

    assign alu_op = alu_op_e'(sw[10:8]);

    alu_unit u_alu (
        .btn   (btn),
        .rst_n (rst_n),
        .a     (sw[3:0]),
        .b     (sw[7:4]),
        .op    (alu_op),
        .res   (alu_res),
        .zero  (alu_zero),
        .ovfl  (alu_ovfl),
        .carry (alu_carry)
    );

    // shamt shares sw[10:8] with the opcode
    barrel_shifter u_shift (
        .btn   (btn),
        .rst_n (rst_n),
        .din   (sw[7:0]),
        .shamt (sw[10:8]),
        .right (sw[11]),
        .arith (sw[12]),
        .res   (shift_res)
    );

    result_display u_disp (
        .btn       (btn),
        .rst_n     (rst_n),
        .mode      (sw[`SW_MODE_BIT]),
        .alu_res   (alu_res),
        .alu_zero  (alu_zero),
        .alu_ovfl  (alu_ovfl),
        .alu_carry (alu_carry),
        .shift_res (shift_res),
        .ledr      (ledr),
        .seg0      (seg0),
        .seg1      (seg1),
        .seg2      (seg2),
        .seg3      (seg3)
    );

endmodule

//--- design/lab_ops_pkg.sv
package lab_ops_pkg;

    // alu opcodes, taken straight from sw[10:8]
    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_not = 3'd2,
        op_and = 3'd3,
        op_or  = 3'd4,
        op_xor = 3'd5,
        op_slt = 3'd6,
        op_eq  = 3'd7
    } alu_op_e;

    // shift kinds
    typedef enum logic [1:0] {
        shift_sll = 2'd0,
        shift_srl = 2'd1,
        shift_sra = 2'd2
    } shift_kind_e;

endpackage

//--- design/result_display.sv
`include "lab_consts.svh"

module result_display (
    input  logic                   btn,
    input  logic                   rst_n,
    input  logic                   mode,
    input  logic [`OPERAND_W-1:0]  alu_res,
    input  logic                   alu_zero,
    input  logic                   alu_ovfl,
    input  logic                   alu_carry,
    input  logic [`DATA_W-1:0]     shift_res,
    output logic [`LED_W-1:0]      ledr,
    output display_pkg::seg_t      seg0,
    output display_pkg::seg_t      seg1,
    output display_pkg::seg_t      seg2,
    output display_pkg::seg_t      seg3
);
    import display_pkg::*;

    logic               mode_q;
    logic [`DATA_W-1:0] sel_res;
    logic               sel_zero;
    logic [`LED_W-1:0]  ledr_next;
    glyph_e             glyph;

    // hex digit, dot off
    function automatic seg_t hex_seg(input logic [3:0] nib);
        case (nib)
            4'h0: hex_seg = 8'hc0;
            4'h1: hex_seg = 8'hf9;
            4'h2: hex_seg = 8'ha4;
            4'h3: hex_seg = 8'hb0;
            4'h4: hex_seg = 8'h99;
            4'h5: hex_seg = 8'h92;
            4'h6: hex_seg = 8'h82;
            4'h7: hex_seg = 8'hf8;
            4'h8: hex_seg = 8'h80;
            4'h9: hex_seg = 8'h90;
            4'ha: hex_seg = 8'h88;
            4'hb: hex_seg = 8'h83;
            4'hc: hex_seg = 8'hc6;
            4'hd: hex_seg = 8'ha1;
            4'he: hex_seg = 8'h86;
            default: hex_seg = 8'h8e;
        endcase
    endfunction

    function automatic seg_t glyph_seg(input glyph_e g);
        case (g)
            glyph_a: glyph_seg = 8'h88;
            glyph_s: glyph_seg = 8'h92;
            default: glyph_seg = 8'hff;
        endcase
    endfunction

    // mode lags one edge to line up with the unit registers
    always_ff @(posedge btn) begin
        if (!rst_n)
            mode_q <= 1'b0;
        else
            mode_q <= mode;
    end

    always_comb begin
        sel_res  = mode_q ? shift_res : {{(`DATA_W-`OPERAND_W){1'b0}}, alu_res};
        sel_zero = mode_q ? (shift_res == '0) : alu_zero;
        glyph    = mode_q ? glyph_s : glyph_a;

        ledr_next = '0;
        ledr_next[`DATA_W-1:0] = sel_res;
        ledr_next[8]  = sel_zero;
        // flags only mean something for the alu
        ledr_next[9]  = !mode_q && alu_ovfl;
        ledr_next[10] = !mode_q && alu_carry;
    end

    always_ff @(posedge btn) begin
        if (!rst_n) begin
            ledr <= '0;
            seg0 <= 8'hff;
            seg1 <= 8'hff;
            seg2 <= 8'hff;
            seg3 <= 8'hff;
        end else begin
            ledr <= ledr_next;
            seg0 <= hex_seg(sel_res[3:0]);
            seg1 <= hex_seg(sel_res[7:4]);
            seg2 <= glyph_seg(glyph);
            seg3 <= glyph_seg(glyph_blank);
        end
    end

endmodule

//--- include/lab_consts.svh
`ifndef LAB_CONSTS_SVH
`define LAB_CONSTS_SVH

// alu operands
`define OPERAND_W 4

// shifter data and amount
`define DATA_W 8
`define SHAMT_W 3

// board io widths
`define SW_W 16
`define LED_W 16
`define SEG_W 8

// mode switch, 1 picks the shifter
`define SW_MODE_BIT 15

`endif

//--- lab_board.f
+incdir+include
design/lab_ops_pkg.sv
design/display_pkg.sv
design/alu_unit.sv
design/barrel_shifter.sv
design/result_display.sv
design/lab_board_top.sv
bench/tb_clock_gen.sv
bench/lab_board_props.sv
bench/lab_board_tb.sv
